// File: ahbApbBridge.f
design/bridgePkg.sv
design/ahbPipeIf.sv
design/ahbSlaveInterface.sv
design/apbFsmController.sv
design/apbReadMux.sv
design/ahbApbBridge.sv
test/apbPeripheralModel.sv
test/ahbApbBridgeTb.sv

// File: design/ahbApbBridge.sv
// AHB-Lite to APB bridge, top level.
// Single and back-to-back transfers only, Hresp is always OKAY.
// Connect Hreadyin to Hreadyout when this is the only AHB slave.
`timescale 1ns/1ns

module ahbApbBridge import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic Hselapb,
	input htransT Htrans,
	input logic Hwrite,
	input logic Hreadyin,
	input dataWordT Haddr,
	input dataWordT Hwdata,
	input dataWordT Prdata0,
	input dataWordT Prdata1,
	input dataWordT Prdata2,
	output dataWordT Paddr,
	output dataWordT Pwdata,
	output logic Pwrite,
	output logic [2:0] Pselx,
	output logic Penable,
	output logic Hreadyout,
	output dataWordT Hrdata
);

	ahbPipeIf pipeBus();

	ahbSlaveInterface slaveSide
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hselapb(Hselapb),
		.Hreadyin(Hreadyin),
		.Hwrite(Hwrite),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Htrans(Htrans),
		.pipe(pipeBus)
	);

	apbFsmController fsmCtrl
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hwrite(Hwrite),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.pipe(pipeBus),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Pwrite(Pwrite),
		.Pselx(Pselx),
		.Penable(Penable),
		.Hreadyout(Hreadyout)
	);

	apbReadMux readMux
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Pselx(Pselx),
		.Penable(Penable),
		.Pwrite(Pwrite),
		.Prdata0(Prdata0),
		.Prdata1(Prdata1),
		.Prdata2(Prdata2),
		.Hrdata(Hrdata)
	);

endmodule

// File: design/ahbPipeIf.sv
// Pipelined AHB fields passed from the AHB input side to the APB FSM.
// Stage 1 fields lag the bus by one clock, stage 2 fields by two.
`timescale 1ns/1ns

interface ahbPipeIf import bridgePkg::*; ();

	logic valid;
	logic Hwritereg;
	dataWordT Haddr1;
	dataWordT Haddr2;
	dataWordT Hwdata1;
	dataWordT Hwdata2;
	logic [2:0] tempselx;

	modport source
	(
		output valid, Hwritereg, Haddr1, Haddr2, Hwdata1, Hwdata2, tempselx
	);

	modport sink
	(
		input valid, Hwritereg, Haddr1, Haddr2, Hwdata1, Hwdata2, tempselx
	);

endinterface

// File: design/ahbSlaveInterface.sv
// AHB-Lite input side of the bridge.
// valid and tempselx decode the current address phase combinationally.
// Hreadyin must be tied to the bridge Hreadyout in a single-slave system.
`timescale 1ns/1ns

module ahbSlaveInterface import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic Hselapb,
	input logic Hreadyin,
	input logic Hwrite,
	input dataWordT Haddr,
	input dataWordT Hwdata,
	input htransT Htrans,
	ahbPipeIf.source pipe
);

	logic activeTrans;
	logic [2:0] selDecode;

	// address and data delay lines.
	always_ff @(posedge Hclk)
	begin
		pipe.Haddr1 <= Haddr;
		pipe.Haddr2 <= pipe.Haddr1;
		pipe.Hwdata1 <= Hwdata;
		pipe.Hwdata2 <= pipe.Hwdata1;
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			pipe.Hwritereg <= 1'b0;
		else
			pipe.Hwritereg <= Hwrite;
	end

	assign activeTrans = (Htrans == NONSEQ) || (Htrans == SEQ); // idle and busy ignored.
	assign selDecode = addrSel(Haddr);

	assign pipe.tempselx = selDecode;
	assign pipe.valid = Hselapb && Hreadyin && activeTrans && (selDecode != 3'b000);

endmodule

// File: design/apbFsmController.sv
// APB sequencer of the bridge, eight states, all outputs registered.
// No APB wait states, Pready is taken as always high.
// A read needs two clocks after its address phase, a write three.
// Hreadyout low stretches the AHB data phase while APB catches up.
`timescale 1ns/1ns

module apbFsmController import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic Hwrite,
	input dataWordT Haddr,
	input dataWordT Hwdata,
	ahbPipeIf.sink pipe,
	output dataWordT Paddr,
	output dataWordT Pwdata,
	output logic Pwrite,
	output logic [2:0] Pselx,
	output logic Penable,
	output logic Hreadyout
);

	apbStateT presentState;
	apbStateT nextState;

	dataWordT paddrNext;
	dataWordT pwdataNext;
	logic pwriteNext;
	logic [2:0] pselxNext;
	logic penableNext;
	logic hreadyoutNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			presentState <= stIdle;
		else
			presentState <= nextState;
	end

	always_comb
	begin
		nextState = presentState;
		paddrNext = Paddr;
		pwdataNext = Pwdata;
		pwriteNext = Pwrite;
		pselxNext = Pselx;
		penableNext = Penable;
		hreadyoutNext = Hreadyout;

		case (presentState)
			stIdle, stREnable, stWEnable:
			begin
				if (presentState == stWEnable)
					pwdataNext = pipe.Hwdata2; // word just written.
				penableNext = 1'b0;
				if (pipe.valid && !Hwrite)
				begin
					nextState = stRead;
					paddrNext = Haddr;
					pwriteNext = 1'b0;
					pselxNext = pipe.tempselx;
					hreadyoutNext = 1'b0; // hold the read data phase.
				end
				else
				begin
					nextState = pipe.valid ? stWwait : stIdle;
					pselxNext = 3'b000;
					hreadyoutNext = 1'b1;
				end
			end

			// write data is on the bus now.
			stWwait:
			begin
				nextState = pipe.valid ? stWriteP : stWrite;
				paddrNext = pipe.Haddr1;
				pwdataNext = Hwdata;
				pwriteNext = 1'b1;
				pselxNext = addrSel(pipe.Haddr1);
				penableNext = 1'b0;
				hreadyoutNext = 1'b0;
			end

			stRead, stWrite:
			begin
				nextState = (presentState == stRead) ? stREnable : stWEnable;
				penableNext = 1'b1;
				hreadyoutNext = 1'b1;
			end

			stWriteP:
			begin
				nextState = stWEnableP;
				penableNext = 1'b1;
				hreadyoutNext = pipe.Hwritereg; // a pending read must wait.
			end

			// Hreadyout high here marks the pending transfer as a write.
			stWEnableP:
			begin
				paddrNext = pipe.Haddr2;
				pselxNext = addrSel(pipe.Haddr2);
				penableNext = 1'b0;
				hreadyoutNext = 1'b0;
				if (Hreadyout)
				begin
					nextState = pipe.valid ? stWriteP : stWrite;
					pwriteNext = 1'b1;
					pwdataNext = pipe.Hwdata1;
				end
				else
				begin
					nextState = stRead;
					pwriteNext = 1'b0;
					pwdataNext = pipe.Hwdata2;
				end
			end

			default:
			begin
				nextState = stIdle;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Pwrite <= 1'b0;
			Pselx <= 3'b000;
			Penable <= 1'b0;
			Hreadyout <= 1'b1; // ready out of reset.
		end
		else
		begin
			Pwrite <= pwriteNext;
			Pselx <= pselxNext;
			Penable <= penableNext;
			Hreadyout <= hreadyoutNext;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr <= paddrNext;
		Pwdata <= pwdataNext;
	end

endmodule

// File: design/apbReadMux.sv
// Read data return path of the bridge.
// Hrdata passes Prdata through during a read enable phase and then
// holds it until the next read completes.
`timescale 1ns/1ns

module apbReadMux import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic [2:0] Pselx,
	input logic Penable,
	input logic Pwrite,
	input dataWordT Prdata0,
	input dataWordT Prdata1,
	input dataWordT Prdata2,
	output dataWordT Hrdata
);

	dataWordT selData;
	dataWordT heldData;
	logic readEnable;

	// one-hot and-or select.
	assign selData = ({32{Pselx[0]}} & Prdata0) |
		({32{Pselx[1]}} & Prdata1) |
		({32{Pselx[2]}} & Prdata2);

	assign readEnable = Penable && !Pwrite;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			heldData <= '0;
		else if (readEnable)
			heldData <= selData;
	end

	assign Hrdata = readEnable ? selData : heldData;

endmodule

// File: design/bridgePkg.sv
// Types, state codes and address map shared by the AHB-to-APB bridge.
// Three APB peripherals, 64 MB each, starting at 0x8000_0000.
// Addresses outside the three ranges decode to an all-zero select.
package bridgePkg;

	typedef logic [31:0] dataWordT;

	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htransT;

	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stREnable  = 3'b101,
		stWEnable  = 3'b110,
		stWEnableP = 3'b111
	} apbStateT;

	localparam dataWordT periph0Base = 32'h8000_0000;
	localparam dataWordT periph0Top  = 32'h83FF_FFFF;
	localparam dataWordT periph1Base = 32'h8400_0000;
	localparam dataWordT periph1Top  = 32'h87FF_FFFF;
	localparam dataWordT periph2Base = 32'h8800_0000;
	localparam dataWordT periph2Top  = 32'h8BFF_FFFF;

	// one-hot peripheral select for an address.
	function automatic logic [2:0] addrSel(input dataWordT addr);
		logic [2:0] sel;
		sel[0] = (addr >= periph0Base) && (addr <= periph0Top);
		sel[1] = (addr >= periph1Base) && (addr <= periph1Top);
		sel[2] = (addr >= periph2Base) && (addr <= periph2Top);
		return sel;
	endfunction

endpackage

// File: run.sh
#!/bin/sh
# Builds the bridge testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f ahbApbBridge.f \
	--top-module ahbApbBridgeTb \
	--Mdir obj_dir \
	-o ahbApbBridgeSim

./obj_dir/ahbApbBridgeSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: test/ahbApbBridgeTb.sv
// Testbench of the AHB-to-APB bridge, acting as the only AHB master.
// Hreadyin is tied to Hreadyout; inputs change 1 ns after the rising edge.
`timescale 1ns/1ns

module ahbApbBridgeTb import bridgePkg::*; ();

	logic Hclk = 1'b0;
	logic Hresetn;
	logic Hselapb;
	logic Hwrite;
	htransT Htrans;
	dataWordT Haddr, Hwdata, Hrdata, Paddr, Pwdata, Prdata0, Prdata1, Prdata2;
	logic Pwrite, Penable, Hreadyout;
	logic [2:0] Pselx;

	integer seed = 32'h8d15;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int setupCount = 0;
	int readyLowCount = 0;
	dataWordT trAddr[$];
	dataWordT trData[$];
	logic trWrite[$];
	dataWordT enAddr[$];
	dataWordT enData[$];
	logic [2:0] enSel[$];
	logic enWrite[$];
	dataWordT expMem[dataWordT];
	dataWordT baseAddr [3] = '{periph0Base, periph1Base, periph2Base};

	always #4 Hclk = ~Hclk;

	ahbApbBridge dut_i
	(
		.Hclk(Hclk), .Hresetn(Hresetn), .Hselapb(Hselapb), .Htrans(Htrans),
		.Hwrite(Hwrite), .Hreadyin(Hreadyout), .Haddr(Haddr), .Hwdata(Hwdata),
		.Prdata0(Prdata0), .Prdata1(Prdata1), .Prdata2(Prdata2),
		.Paddr(Paddr), .Pwdata(Pwdata), .Pwrite(Pwrite), .Pselx(Pselx),
		.Penable(Penable), .Hreadyout(Hreadyout), .Hrdata(Hrdata)
	);

	apbPeripheralModel periphs
	(
		.Hclk(Hclk), .Hresetn(Hresetn), .Pselx(Pselx), .Penable(Penable),
		.Pwrite(Pwrite), .Paddr(Paddr), .Pwdata(Pwdata),
		.Prdata0(Prdata0), .Prdata1(Prdata1), .Prdata2(Prdata2)
	);

	assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(Pselx))
	else
	begin
		errorCount++;
		$display("More than one Pselx bit set at %0t", $time);
	end
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> (Pselx != 3'b000) && !$past(Penable) && ($past(Pselx) == Pselx))
	else
	begin
		errorCount++;
		$display("Penable without a matching setup at %0t", $time);
	end
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> $stable(Paddr) && $stable(Pwrite))
	else
	begin
		errorCount++;
		$display("Paddr or Pwrite moved in enable at %0t", $time);
	end

	// APB phase log, sampled mid-cycle.
	always @(negedge Hclk)
	begin
		if (Hresetn)
		begin
			if ((Pselx != 3'b000) && !Penable)
				setupCount++;
			if (Penable)
			begin
				enAddr.push_back(Paddr);
				enData.push_back(Pwdata);
				enSel.push_back(Pselx);
				enWrite.push_back(Pwrite);
			end
			if (!Hreadyout)
				readyLowCount++;
		end
	end

	function automatic int periphIndex(input dataWordT addr);
		if (addr >= periph0Base && addr <= periph0Top)
			return 0;
		if (addr >= periph1Base && addr <= periph1Top)
			return 1;
		if (addr >= periph2Base && addr <= periph2Top)
			return 2;
		return -1;
	endfunction

	function automatic dataWordT expectedRead(input dataWordT addr);
		if (expMem.exists(addr))
			return expMem[addr];
		return (addr ^ 32'hA5A5_0000) + dataWordT'(periphIndex(addr));
	endfunction

	function automatic dataWordT randomAddr(input int p);
		return baseAddr[p] + (dataWordT'($random(seed)) & 32'h0000_007C);
	endfunction

	task automatic queueTransfer(input dataWordT addr, input logic wr, input dataWordT data);
		trAddr.push_back(addr);
		trWrite.push_back(wr);
		trData.push_back(data);
	endtask

	task automatic check(input logic ok, input string what, input dataWordT got,
		input dataWordT exp);
		if (!ok)
		begin
			errorCount++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// AHB master: runs the queued transfers pipelined, advancing on Hreadyout.
	task automatic runBus();
		int curAddr;
		int curData;
		int guard;
		logic ready;
		curAddr = 0;
		curData = -1;
		guard = 0;
		@(posedge Hclk);
		#1;
		Hselapb = 1'b1;
		Htrans = NONSEQ;
		Haddr = trAddr[0];
		Hwrite = trWrite[0];
		while ((curAddr >= 0 || curData >= 0) && guard < 40 * trAddr.size())
		begin
			@(negedge Hclk);
			ready = Hreadyout;
			if (ready && curData >= 0)
			begin
				if (trWrite[curData])
					expMem[trAddr[curData]] = trData[curData];
				else
					check(Hrdata === expectedRead(trAddr[curData]), "Hrdata", Hrdata,
						expectedRead(trAddr[curData]));
			end
			@(posedge Hclk);
			#1;
			if (ready)
			begin
				curData = curAddr;
				if (curData >= 0 && trWrite[curData])
					Hwdata = trData[curData];
				if (curAddr >= 0 && curAddr + 1 < trAddr.size())
				begin
					curAddr++;
					Haddr = trAddr[curAddr];
					Hwrite = trWrite[curAddr];
				end
				else
				begin
					curAddr = -1;
					Htrans = IDLE;
				end
			end
			guard++;
		end
		trAddr.delete();
		trWrite.delete();
		trData.delete();
		if (curAddr >= 0 || curData >= 0)
		begin
			errorCount++;
			$display("Timeout: Hreadyout never completed the queued AHB transfers");
		end
	endtask

	task automatic endTest(input string name, input int errBefore);
		testsRun++;
		if (errorCount > errBefore)
		begin
			testsFailed++;
			$display("test %s: failed with %0d errors", name, errorCount - errBefore);
		end
		else
			$display("test %s: passed", name);
	endtask

	initial
	begin
		int errBefore;
		int setupBefore;
		int enBefore;
		int readyBefore;
		dataWordT addr;
		dataWordT data;
		dataWordT written[$];
		Hresetn = 1'b0;
		Hselapb = 1'b0;
		Htrans = IDLE;
		Hwrite = 1'b0;
		Haddr = '0;
		Hwdata = '0;
		repeat (4) @(posedge Hclk);
		#1 Hresetn = 1'b1;

		errBefore = errorCount;
		@(negedge Hclk);
		check(Pselx == 3'b000 && !Penable && Hreadyout, "reset outputs",
			32'({Pselx, Penable, Hreadyout}), 32'h1);
		setupBefore = setupCount;
		enBefore = enAddr.size();
		@(posedge Hclk);
		#1 Hselapb = 1'b1;
		Haddr = periph1Base;
		repeat (3) @(posedge Hclk); // idle Htrans.
		#1 Hselapb = 1'b0;
		Htrans = NONSEQ;
		repeat (3) @(posedge Hclk); // deselected.
		#1 Htrans = IDLE;
		repeat (3) @(posedge Hclk);
		check(setupCount == setupBefore && enAddr.size() == enBefore, "idle APB phases",
			setupCount - setupBefore, 0);
		endTest("reset and idle", errBefore);

		errBefore = errorCount;
		for (int p = 0; p < 3; p++)
		begin
			addr = randomAddr(p);
			data = $random(seed);
			written.push_back(addr);
			setupBefore = setupCount;
			enBefore = enAddr.size();
			queueTransfer(addr, 1'b1, data);
			runBus();
			repeat (3) @(posedge Hclk);
			check(setupCount - setupBefore == 1, "setup count", setupCount - setupBefore, 1);
			check(enAddr.size() - enBefore == 1, "enable count", enAddr.size() - enBefore, 1);
			if (enAddr.size() > enBefore)
			begin
				check(enAddr[enBefore] == addr, "Paddr", enAddr[enBefore], addr);
				check(enData[enBefore] == data, "Pwdata", enData[enBefore], data);
				check(enSel[enBefore] == 3'(1 << p), "Pselx", 32'(enSel[enBefore]), 1 << p);
				check(enWrite[enBefore] == 1'b1, "Pwrite", 32'(enWrite[enBefore]), 1);
			end
		end
		endTest("single writes", errBefore);

		errBefore = errorCount;
		for (int p = 0; p < 3; p++)
			queueTransfer(baseAddr[p] + 32'h80 + 32'(4 * p), 1'b0, '0); // never written.
		foreach (written[i])
			queueTransfer(written[i], 1'b0, '0);
		runBus();
		endTest("reads", errBefore);

		errBefore = errorCount;
		written.delete();
		enBefore = enAddr.size();
		for (int i = 0; i < 6; i++)
		begin
			addr = randomAddr(($random(seed) & 32'h7fff_ffff) % 3);
			written.push_back(addr);
			queueTransfer(addr, 1'b1, $random(seed));
		end
		foreach (written[i])
			queueTransfer(written[i], 1'b0, '0);
		runBus();
		repeat (3) @(posedge Hclk);
		check(enAddr.size() - enBefore == 12, "enable count", enAddr.size() - enBefore, 12);
		for (int i = 0; i < 12 && enBefore + i < enAddr.size(); i++)
			check(enAddr[enBefore + i] == written[i % 6], "pipelined Paddr",
				enAddr[enBefore + i], written[i % 6]);
		endTest("pipelined transfers", errBefore);

		errBefore = errorCount;
		setupBefore = setupCount;
		enBefore = enAddr.size();
		readyBefore = readyLowCount;
		queueTransfer(32'h9000_0010, 1'b1, 32'h1234_5678);
		queueTransfer(32'h7000_0000, 1'b1, 32'h9abc_def0);
		runBus();
		repeat (3) @(posedge Hclk);
		check(setupCount == setupBefore && enAddr.size() == enBefore, "out of range select",
			setupCount - setupBefore, 0);
		check(readyLowCount == readyBefore, "out of range Hreadyout low cycles",
			readyLowCount - readyBefore, 0);
		endTest("out of range", errBefore);

		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: test/apbPeripheralModel.sv
// Three APB slaves with no wait states, 64 words each, indexed by Paddr[7:2].
// Unwritten words read as (Paddr ^ 32'hA5A5_0000) + peripheral index.
`timescale 1ns/1ns

module apbPeripheralModel import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic [2:0] Pselx,
	input logic Penable,
	input logic Pwrite,
	input dataWordT Paddr,
	input dataWordT Pwdata,
	output dataWordT Prdata0,
	output dataWordT Prdata1,
	output dataWordT Prdata2
);

	dataWordT mem [3][64];
	logic written [3][64];
	dataWordT rdata [3];

	always_ff @(posedge Hclk)
	begin
		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 64; j++)
			begin
				if (!Hresetn)
					written[i][j] <= 1'b0;
				else if (Pselx[i] && Penable && Pwrite && (j == int'(Paddr[7:2])))
				begin
					mem[i][j] <= Pwdata;
					written[i][j] <= 1'b1;
				end
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (written[i][Paddr[7:2]])
				rdata[i] = mem[i][Paddr[7:2]];
			else
				rdata[i] = (Paddr ^ 32'hA5A5_0000) + dataWordT'(i); // fresh word.
		end
	end

	assign Prdata0 = rdata[0];
	assign Prdata1 = rdata[1];
	assign Prdata2 = rdata[2];

endmodule
